//--- src/vgaTimingPkg.sv
package vgaTimingPkg;

	// Horizontal geometry in pixels, one pixel per clock
	localparam int hVisible = 640;
	localparam int hFront = 16;
	localparam int hSyncLen = 96;
	localparam int hTotal = 800;   // Back porch is whatever is left of the line

	// Vertical geometry in lines
	localparam int vVisible = 480;
	localparam int vFront = 10;
	localparam int vSyncLen = 2;
	localparam int vTotal = 525;

	// Sync windows, first count inside and first count past the pulse
	localparam int hSyncStart = hVisible + hFront;
	localparam int hSyncEnd = hSyncStart + hSyncLen;
	localparam int vSyncStart = vVisible + vFront;
	localparam int vSyncEnd = vSyncStart + vSyncLen;

	// Wide enough for hTotal and vTotal
	typedef logic [9:0] coord_t;

	localparam logic syncActive = 1'b0;   // Both syncs pulse low

endpackage

//--- src/glyphPkg.sv
package glyphPkg;

	localparam int cellWidth = 8;
	localparam int cellHeight = 16;
	localparam int msgLength = 8;     // Character slots per layer
	localparam int numGlyphs = 7;     // Blank plus six letters

	localparam int colBits = $clog2(cellWidth);    // Column inside a cell
	localparam int slotBits = $clog2(msgLength);   // Slot index inside a message
	localparam int regionWidth = msgLength * cellWidth;

	typedef logic [2:0] glyph_t;
	typedef logic [3:0] glyphRow_t;
	typedef logic [6:0] glyphAddr_t;   // {glyph_t, glyphRow_t}
	typedef logic [7:0] rowBits_t;     // Bit n lights pixel column n from the left
	typedef logic [2:0] color_t;       // R in bit 2, G in bit 1, B in bit 0

	// Slot 0 sits at the left edge of the region
	typedef glyph_t [0:msgLength-1] message_t;

	localparam glyph_t gBlank = 3'd0;
	localparam glyph_t gJ = 3'd1;
	localparam glyph_t gV = 3'd2;
	localparam glyph_t gM = 3'd3;
	localparam glyph_t gB = 3'd4;
	localparam glyph_t gS = 3'd5;
	localparam glyph_t gL = 3'd6;

	// Rows run top to bottom, and the hex values read mirrored since bit 0 is the left pixel
	localparam rowBits_t font [0:numGlyphs-1][0:cellHeight-1] = '{
		'{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,   // Blank
		  8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
		'{8'h00, 8'h00, 8'h7C, 8'h10, 8'h10, 8'h10, 8'h10, 8'h10,   // J
		  8'h10, 8'h10, 8'h12, 8'h12, 8'h0C, 8'h00, 8'h00, 8'h00},
		'{8'h00, 8'h00, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42,   // V
		  8'h24, 8'h24, 8'h24, 8'h18, 8'h18, 8'h00, 8'h00, 8'h00},
		'{8'h00, 8'h00, 8'h42, 8'h66, 8'h5A, 8'h5A, 8'h42, 8'h42,   // M
		  8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h00, 8'h00, 8'h00},
		'{8'h00, 8'h00, 8'h1E, 8'h22, 8'h22, 8'h22, 8'h22, 8'h1E,   // B
		  8'h22, 8'h22, 8'h22, 8'h22, 8'h1E, 8'h00, 8'h00, 8'h00},
		'{8'h00, 8'h00, 8'h3C, 8'h42, 8'h02, 8'h02, 8'h1C, 8'h20,   // S
		  8'h40, 8'h40, 8'h40, 8'h42, 8'h3C, 8'h00, 8'h00, 8'h00},
		'{8'h00, 8'h00, 8'h02, 8'h02, 8'h02, 8'h02, 8'h02, 8'h02,   // L
		  8'h02, 8'h02, 8'h02, 8'h02, 8'h7E, 8'h00, 8'h00, 8'h00}
	};

	// Top two rows of every glyph are empty, so the first line after reset needs no prefetch

	localparam logic [9:0] layer0OriginX = 10'd0;
	localparam logic [9:0] layer0OriginY = 10'd0;
	localparam message_t layer0Msg = '{gJ, gV, gBlank, gM, gB, gBlank, gS, gL};

	// Second layer is offset so that it overlaps the first one
	localparam logic [9:0] layer1OriginX = 10'd40;
	localparam logic [9:0] layer1OriginY = 10'd8;
	localparam message_t layer1Msg = '{gL, gS, gB, gM, gV, gJ, gJ, gV};

endpackage

//--- src/syncGen.sv
`timescale 1ns/1ns

module syncGen (
	input logic clk,
	input logic rst,
	output vgaTimingPkg::coord_t hPos,
	output vgaTimingPkg::coord_t vPos,
	output logic visible,
	output logic hSyncRaw,
	output logic vSyncRaw,
	output logic lineStart
);
	import vgaTimingPkg::*;

	logic lineEnd;    // Last pixel of the line
	logic frameEnd;   // Last line of the frame
	logic inHSync;
	logic inVSync;

	assign lineEnd = (hPos == coord_t'(hTotal - 1));
	assign frameEnd = (vPos == coord_t'(vTotal - 1));

	// Pixel counter wraps every line and steps the line counter as it does
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hPos <= '0;
			vPos <= '0;
		end
		else if (lineEnd)
		begin
			hPos <= '0;
			vPos <= frameEnd ? '0 : vPos + 1'b1;
		end
		else
			hPos <= hPos + 1'b1;
	end

	assign inHSync = (hPos >= coord_t'(hSyncStart)) && (hPos < coord_t'(hSyncEnd));
	assign inVSync = (vPos >= coord_t'(vSyncStart)) && (vPos < coord_t'(vSyncEnd));

	assign hSyncRaw = inHSync ? syncActive : ~syncActive;
	assign vSyncRaw = inVSync ? syncActive : ~syncActive;

	assign visible = (hPos < coord_t'(hVisible)) && (vPos < coord_t'(vVisible));

	// Fires on the first blanking pixel so the layers get the whole blanking interval
	assign lineStart = (hPos == coord_t'(hVisible));

endmodule

//--- src/glyphRom.sv
`timescale 1ns/1ns

module glyphRom (
	input logic clk,
	input logic rst,
	input logic romReq,
	input glyphPkg::glyphAddr_t romAddr,
	output logic romAck,
	output glyphPkg::rowBits_t romData
);
	import glyphPkg::*;

	glyph_t code;
	glyphRow_t row;
	rowBits_t rowLookup;   // Font row for the current address

	assign code = romAddr[$bits(glyphAddr_t)-1 -: $bits(glyph_t)];
	assign row = romAddr[$bits(glyphRow_t)-1:0];

	// Code 7 has no glyph and reads as an empty row
	assign rowLookup = (code < glyph_t'(numGlyphs)) ? font[code][row] : '0;

	// Responder half of the four-phase handshake
	always_ff @(posedge clk)
	begin
		if (rst)
			romAck <= 1'b0;
		else if (romReq && !romAck)
			romAck <= 1'b1;   // Answer one cycle after the request is seen
		else if (!romReq)
			romAck <= 1'b0;   // Return to zero once the requester lets go
	end

	// Row is captured on the same edge that raises romAck and held through the ack phase
	always_ff @(posedge clk)
	begin
		if (romReq && !romAck)
			romData <= rowLookup;
	end

endmodule

//--- src/romArbiter.sv
`timescale 1ns/1ns

module romArbiter (
	input logic clk,
	input logic rst,
	input logic req0,
	input glyphPkg::glyphAddr_t addr0,
	output logic ack0,
	output glyphPkg::rowBits_t data0,
	input logic req1,
	input glyphPkg::glyphAddr_t addr1,
	output logic ack1,
	output glyphPkg::rowBits_t data1,
	output logic romReq,
	output glyphPkg::glyphAddr_t romAddr,
	input logic romAck,
	input glyphPkg::rowBits_t romData
);

	logic busy;       // A transfer owns the ROM
	logic grant;      // Port being served while busy
	logic ptr;        // Port that wins the next tie
	logic pick;       // Winner among the ports asking right now
	logic grantReq;   // Request line of the granted port

	// A lone requester always wins, the pointer only settles ties
	assign pick = (req0 && req1) ? ptr : req1;

	assign grantReq = grant ? req1 : req0;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			grant <= 1'b0;
			ptr <= 1'b0;
		end
		else if (!busy)
		begin
			if (req0 || req1)
			begin
				busy <= 1'b1;
				grant <= pick;   // Held for the whole four-phase transfer
			end
		end
		else if (!grantReq && !romAck)
		begin
			busy <= 1'b0;     // Both halves are back to zero so the transfer is done
			ptr <= ~grant;    // Served port drops to low priority
		end
	end

	// Only the granted port reaches the ROM
	assign romReq = busy && grantReq;
	assign romAddr = grant ? addr1 : addr0;

	// The waiting port sees neither ack nor data
	assign ack0 = busy && !grant && romAck;
	assign ack1 = busy && grant && romAck;
	assign data0 = (busy && !grant) ? romData : '0;
	assign data1 = (busy && grant) ? romData : '0;

endmodule

//--- src/textLayer.sv
`timescale 1ns/1ns

module textLayer #(
	parameter vgaTimingPkg::coord_t originX = '0,
	parameter vgaTimingPkg::coord_t originY = '0,
	parameter glyphPkg::message_t message = '0
) (
	input logic clk,
	input logic rst,
	input vgaTimingPkg::coord_t hPos,
	input vgaTimingPkg::coord_t vPos,
	input logic lineStart,
	input glyphPkg::color_t layerColorIn,
	output logic req,
	output glyphPkg::glyphAddr_t addr,
	input logic ack,
	input glyphPkg::rowBits_t data,
	output logic lit,
	output glyphPkg::color_t layerColor
);
	import vgaTimingPkg::*;
	import glyphPkg::*;

	typedef enum logic [1:0] {sIdle, sScan, sWait, sRelease} fetchState_t;

	fetchState_t state;
	logic [slotBits-1:0] slot;       // Slot being fetched
	glyphRow_t fetchRow;             // Glyph row needed by the next line
	rowBits_t shadowBuf [msgLength]; // Filled during blanking
	rowBits_t liveBuf [msgLength];   // Drawn from during the visible part
	logic lastSlot;

	coord_t nextLine;
	coord_t bandOffset;
	logic nextInBand;

	coord_t relX;
	logic [slotBits-1:0] pixSlot;
	logic [colBits-1:0] pixCol;
	logic inRegion;

	// Line that the prefetch prepares, with the wrap at the end of the frame
	assign nextLine = (vPos == coord_t'(vTotal - 1)) ? '0 : vPos + 1'b1;
	assign bandOffset = nextLine - originY;
	assign nextInBand = (nextLine >= originY) && (nextLine < originY + cellHeight);

	assign lastSlot = (slot == slotBits'(msgLength - 1));

	// Fetch FSM walks the slots in order and runs one handshake per lettered slot
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= sIdle;
			slot <= '0;
			fetchRow <= '0;
			req <= 1'b0;
			for (int i = 0; i < msgLength; i++)
				shadowBuf[i] <= '0;
		end
		else
		begin
			case (state)
				sIdle:
					if (lineStart && nextInBand)
					begin
						fetchRow <= bandOffset[$bits(glyphRow_t)-1:0];
						slot <= '0;
						state <= sScan;
					end
				sScan:
					if (message[slot] == gBlank)
					begin
						shadowBuf[slot] <= '0;   // Blank slot needs no ROM access
						state <= sRelease;
					end
					else
					begin
						req <= 1'b1;   // addr is loaded on the same edge
						state <= sWait;
					end
				sWait:
					if (ack)
					begin
						shadowBuf[slot] <= data;
						req <= 1'b0;
						state <= sRelease;
					end
				sRelease:
					if (!ack)   // Wait for the return to zero before the next request
					begin
						if (lastSlot)
							state <= sIdle;
						else
						begin
							slot <= slot + 1'b1;
							state <= sScan;
						end
					end
				default:
					state <= sIdle;
			endcase
		end
	end

	// Address stays put from the rise of req until the next slot is scanned
	always_ff @(posedge clk)
	begin
		if (state == sScan)
			addr <= {message[slot], fetchRow};
	end

	// The prefetched line goes live exactly as the counter wraps to pixel 0
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < msgLength; i++)
				liveBuf[i] <= '0;
		end
		else if (hPos == coord_t'(hTotal - 1))
			liveBuf <= shadowBuf;
	end

	assign relX = hPos - originX;
	assign pixCol = relX[colBits-1:0];
	assign pixSlot = relX[colBits +: slotBits];

	assign inRegion = (hPos >= originX) && (hPos < originX + regionWidth)
		&& (vPos >= originY) && (vPos < originY + cellHeight);

	assign lit = inRegion && liveBuf[pixSlot][pixCol];

	// Switch color only gets through on a lit pixel
	assign layerColor = lit ? layerColorIn : '0;

endmodule

//--- src/videoOut.sv
`timescale 1ns/1ns

module videoOut (
	input logic clk,
	input logic rst,
	input vgaTimingPkg::coord_t hPos,
	input vgaTimingPkg::coord_t vPos,
	input logic visible,
	input logic hSyncRaw,
	input logic vSyncRaw,
	input logic lit0,
	input glyphPkg::color_t color0,
	input logic lit1,
	input glyphPkg::color_t color1,
	output glyphPkg::color_t rgb,
	output logic hSync,
	output logic vSync,
	output vgaTimingPkg::coord_t pixelX,
	output vgaTimingPkg::coord_t pixelY
);
	import vgaTimingPkg::*;
	import glyphPkg::*;

	color_t pixColor;   // Color of the current pixel before the register

	// Layer 0 sits on top, and blanking overrides everything
	always_comb
	begin
		if (!visible)
			pixColor = '0;
		else if (lit0)
			pixColor = color0;
		else if (lit1)
			pixColor = color1;
		else
			pixColor = '0;
	end

	// One register stage for every output keeps color, syncs and position on the same pixel
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rgb <= '0;
			hSync <= ~syncActive;
			vSync <= ~syncActive;
			pixelX <= '0;
			pixelY <= '0;
		end
		else
		begin
			rgb <= pixColor;
			hSync <= hSyncRaw;
			vSync <= vSyncRaw;
			pixelX <= hPos;
			pixelY <= vPos;
		end
	end

endmodule

//--- src/textOverlayTop.sv
`timescale 1ns/1ns

module textOverlayTop (
	input logic clk,
	input logic rst,
	input glyphPkg::color_t color0,
	input glyphPkg::color_t color1,
	output glyphPkg::color_t rgb,
	output logic hSync,
	output logic vSync,
	output vgaTimingPkg::coord_t pixelX,
	output vgaTimingPkg::coord_t pixelY
);
	import vgaTimingPkg::*;
	import glyphPkg::*;

	coord_t hPos;
	coord_t vPos;
	logic visible;
	logic hSyncRaw;
	logic vSyncRaw;
	logic lineStart;

	// Layer 0 side of the arbiter
	logic req0;
	glyphAddr_t addr0;
	logic ack0;
	rowBits_t data0;

	// Layer 1 side of the arbiter
	logic req1;
	glyphAddr_t addr1;
	logic ack1;
	rowBits_t data1;

	logic romReq;
	glyphAddr_t romAddr;
	logic romAck;
	rowBits_t romData;

	logic lit0;
	logic lit1;
	color_t layerColor0;
	color_t layerColor1;

	syncGen timing (
		.clk(clk),
		.rst(rst),
		.hPos(hPos),
		.vPos(vPos),
		.visible(visible),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw),
		.lineStart(lineStart)
	);

	textLayer #(
		.originX(layer0OriginX),
		.originY(layer0OriginY),
		.message(layer0Msg)
	) layer0 (
		.clk(clk),
		.rst(rst),
		.hPos(hPos),
		.vPos(vPos),
		.lineStart(lineStart),
		.layerColorIn(color0),
		.req(req0),
		.addr(addr0),
		.ack(ack0),
		.data(data0),
		.lit(lit0),
		.layerColor(layerColor0)
	);

	textLayer #(
		.originX(layer1OriginX),
		.originY(layer1OriginY),
		.message(layer1Msg)
	) layer1 (
		.clk(clk),
		.rst(rst),
		.hPos(hPos),
		.vPos(vPos),
		.lineStart(lineStart),
		.layerColorIn(color1),
		.req(req1),
		.addr(addr1),
		.ack(ack1),
		.data(data1),
		.lit(lit1),
		.layerColor(layerColor1)
	);

	romArbiter arbiter (
		.clk(clk),
		.rst(rst),
		.req0(req0),
		.addr0(addr0),
		.ack0(ack0),
		.data0(data0),
		.req1(req1),
		.addr1(addr1),
		.ack1(ack1),
		.data1(data1),
		.romReq(romReq),
		.romAddr(romAddr),
		.romAck(romAck),
		.romData(romData)
	);

	glyphRom rom (
		.clk(clk),
		.rst(rst),
		.romReq(romReq),
		.romAddr(romAddr),
		.romAck(romAck),
		.romData(romData)
	);

	videoOut outStage (
		.clk(clk),
		.rst(rst),
		.hPos(hPos),
		.vPos(vPos),
		.visible(visible),
		.hSyncRaw(hSyncRaw),
		.vSyncRaw(vSyncRaw),
		.lit0(lit0),
		.color0(layerColor0),
		.lit1(lit1),
		.color1(layerColor1),
		.rgb(rgb),
		.hSync(hSync),
		.vSync(vSync),
		.pixelX(pixelX),
		.pixelY(pixelY)
	);

endmodule

//--- dv/romHandshake_assertions.sv
`timescale 1ns/1ns

module romHandshake_assertions (
	input logic clk,
	input logic rst,
	input logic req0,
	input glyphPkg::glyphAddr_t addr0,
	input logic ack0,
	input logic req1,
	input glyphPkg::glyphAddr_t addr1,
	input logic ack1,
	input logic romReq,
	input glyphPkg::glyphAddr_t romAddr,
	input logic romAck
);

	localparam int ackLimit = 10;   // Cycles a layer may wait for its row

	logic [3:0] wait0;   // Cycles layer 0 has been waiting so far
	logic [3:0] wait1;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wait0 <= '0;
			wait1 <= '0;
		end
		else
		begin
			wait0 <= (req0 && !ack0) ? wait0 + 1'b1 : '0;
			wait1 <= (req1 && !ack1) ? wait1 + 1'b1 : '0;
		end
	end

	// Layer 0 port
	req0Held: assert property (@(posedge clk) disable iff (rst) req0 && !ack0 |=> req0)
		else $error("Layer 0 dropped its request before the acknowledge");
	addr0Stable: assert property (@(posedge clk) disable iff (rst) req0 && !ack0 |=> $stable(addr0))
		else $error("Layer 0 changed its address while waiting");
	ack0Held: assert property (@(posedge clk) disable iff (rst) ack0 && req0 |=> ack0)
		else $error("Layer 0 acknowledge fell before its request");

	// Layer 1 port
	req1Held: assert property (@(posedge clk) disable iff (rst) req1 && !ack1 |=> req1)
		else $error("Layer 1 dropped its request before the acknowledge");
	addr1Stable: assert property (@(posedge clk) disable iff (rst) req1 && !ack1 |=> $stable(addr1))
		else $error("Layer 1 changed its address while waiting");
	ack1Held: assert property (@(posedge clk) disable iff (rst) ack1 && req1 |=> ack1)
		else $error("Layer 1 acknowledge fell before its request");

	// ROM side of the arbiter
	romReqHeld: assert property (@(posedge clk) disable iff (rst) romReq && !romAck |=> romReq)
		else $error("ROM request dropped before the acknowledge");
	romAddrStable: assert property (@(posedge clk) disable iff (rst)
		romReq && !romAck |=> $stable(romAddr))
		else $error("ROM address changed while the request waited");
	romAckHeld: assert property (@(posedge clk) disable iff (rst) romAck && romReq |=> romAck)
		else $error("ROM acknowledge fell before the request");

	// Every ROM answer is steered to exactly one layer port
	oneGrant: assert property (@(posedge clk) disable iff (rst) romAck |-> (ack0 != ack1))
		else $error("ROM acknowledge did not reach exactly one layer port");

	wait0Bound: assert property (@(posedge clk) disable iff (rst) wait0 < ackLimit)
		else $error("Layer 0 request not acknowledged within the cycle limit");
	wait1Bound: assert property (@(posedge clk) disable iff (rst) wait1 < ackLimit)
		else $error("Layer 1 request not acknowledged within the cycle limit");

endmodule

//--- dv/textOverlayTb.sv
`timescale 1ns/1ns

module textOverlayTb;
	import vgaTimingPkg::*;
	import glyphPkg::*;

	localparam int resetCycles = 5;
	localparam int timeoutCycles = 2 * hTotal * vTotal + 1000;   // Two whole frames plus margin

	logic clk = 1'b0;   // Starts low so the first edge is a rising one
	logic rst;
	color_t color0;
	color_t color1;
	color_t rgb;
	logic hSync;
	logic vSync;
	coord_t pixelX;
	coord_t pixelY;

	logic rstSeen;        // Reset level at the last rising edge
	color_t seenColor0;   // Colors the last registered pixel was built from
	color_t seenColor1;
	int hModel;           // Raster position the DUT is working on now
	int vModel;
	int expX;             // Position the outputs should describe
	int expY;
	int cycleCount;
	int errorCount;
	int framesDone;
	logic [31:0] lcgState;

	textOverlayTop dut0 (
		.clk(clk),
		.rst(rst),
		.color0(color0),
		.color1(color1),
		.rgb(rgb),
		.hSync(hSync),
		.vSync(vSync),
		.pixelX(pixelX),
		.pixelY(pixelY)
	);

	bind romArbiter romHandshake_assertions handshakeChecks (
		.clk(clk),
		.rst(rst),
		.req0(req0),
		.addr0(addr0),
		.ack0(ack0),
		.req1(req1),
		.addr1(addr1),
		.ack1(ack1),
		.romReq(romReq),
		.romAddr(romAddr),
		.romAck(romAck)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic inBox(input int x, input int y, input int ox, input int oy);
		return (x >= ox) && (x < ox + msgLength * cellWidth)
			&& (y >= oy) && (y < oy + cellHeight);
	endfunction

	// Font bit for a screen pixel of one layer, worked out from its origin and message
	function automatic logic glyphPixel(input int x, input int y, input int ox, input int oy,
		input message_t msg);
		int dx;
		int dy;
		glyph_t code;
		rowBits_t bits;
		if (!inBox(x, y, ox, oy))
			return 1'b0;
		dx = x - ox;
		dy = y - oy;
		code = msg[dx / cellWidth];
		bits = font[code][dy];
		return bits[dx % cellWidth];   // Bit 0 is the leftmost column
	endfunction

	function automatic color_t expectedRgb(input int x, input int y, input color_t c0,
		input color_t c1);
		if (x >= hVisible || y >= vVisible)
			return '0;
		if (glyphPixel(x, y, layer0OriginX, layer0OriginY, layer0Msg))
			return c0;   // Layer 0 wins wherever it is lit
		if (glyphPixel(x, y, layer1OriginX, layer1OriginY, layer1Msg))
			return c1;
		return '0;
	endfunction

	function automatic logic syncLow(input int pos, input int visLen, input int front,
		input int len);
		return (pos >= visLen + front) && (pos < visLen + front + len);
	endfunction

	// Names the kind of pixel so that an error line tells which behavior broke
	function automatic string areaName(input int x, input int y);
		logic in0;
		logic in1;
		in0 = inBox(x, y, layer0OriginX, layer0OriginY);
		in1 = inBox(x, y, layer1OriginX, layer1OriginY);
		if (x >= hVisible || y >= vVisible)
			return "blanking";
		if (in0 && in1)
			return "overlap";
		if (in0)
			return "layer0 glyph";
		if (in1)
			return "layer1 glyph";
		return "background";
	endfunction

	task automatic stopOnFailure();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic valueMismatch(input string testName, input int expected, input int actual);
		errorCount++;
		$display("** Error: %s expected %0d actual %0d at pixel (%0d, %0d)",
			testName, expected, actual, expX, expY);
		stopOnFailure();
	endtask

	task automatic drawColors();
		lcgState = lcgNext(lcgState);
		color0 = lcgState[30:28];   // Upper bits of an LCG are the least regular
		lcgState = lcgNext(lcgState);
		color1 = lcgState[30:28];
	endtask

	// Mirror of the raster, the outputs trail the counters by one register stage
	always @(posedge clk)
	begin
		rstSeen <= rst;
		seenColor0 <= color0;
		seenColor1 <= color1;
		if (rst)
		begin
			hModel <= 0;
			vModel <= 0;
			expX <= 0;
			expY <= 0;
		end
		else
		begin
			expX <= hModel;
			expY <= vModel;
			if (hModel == hTotal - 1)
			begin
				hModel <= 0;
				vModel <= (vModel == vTotal - 1) ? 0 : vModel + 1;
			end
			else
				hModel <= hModel + 1;
		end
	end

	// Outputs have settled by the falling edge
	always @(negedge clk)
	begin
		color_t expRgb;
		if (rstSeen)
		begin
			assert (rgb == '0) else valueMismatch("reset rgb", 0, rgb);
			assert (hSync == 1'b1) else valueMismatch("reset hSync", 1, hSync);
			assert (vSync == 1'b1) else valueMismatch("reset vSync", 1, vSync);
		end
		else
		begin
			expRgb = expectedRgb(expX, expY, seenColor0, seenColor1);
			assert (pixelX == coord_t'(expX)) else valueMismatch("pixelX", expX, pixelX);
			assert (pixelY == coord_t'(expY)) else valueMismatch("pixelY", expY, pixelY);
			assert (hSync == !syncLow(expX, hVisible, hFront, hSyncLen))
				else valueMismatch("hSync", !syncLow(expX, hVisible, hFront, hSyncLen), hSync);
			assert (vSync == !syncLow(expY, vVisible, vFront, vSyncLen))
				else valueMismatch("vSync", !syncLow(expY, vVisible, vFront, vSyncLen), vSync);
			assert (rgb == expRgb) else valueMismatch(areaName(expX, expY), expRgb, rgb);
		end
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("Timeout: two frames did not complete within %0d cycles", timeoutCycles);
			stopOnFailure();
		end
	end

	initial
	begin
		rst = 1'b1;
		cycleCount = 0;
		errorCount = 0;
		framesDone = 0;
		lcgState = 32'd39873;
		drawColors();
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (framesDone < 2)
		begin
			@(negedge clk);
			if (expX == hTotal - 1)
			begin
				drawColors();   // Counter sits on pixel 0 of the next line here
				if (expY == vTotal - 1)
					framesDone++;
			end
		end
		@(posedge clk);   // Last pixel has been compared by now
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- textOverlayTop.f
src/vgaTimingPkg.sv
src/glyphPkg.sv
src/syncGen.sv
src/glyphRom.sv
src/romArbiter.sv
src/textLayer.sv
src/videoOut.sv
src/textOverlayTop.sv
dv/romHandshake_assertions.sv
dv/textOverlayTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and decide the verdict from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module textOverlayTb -f textOverlayTop.f &&
./obj_dir/VtextOverlayTb | tee /dev/stderr | grep -qF '*** TEST PASSED ***' &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }
